/* src/gmii_tx_pkg.sv */
// --------------------------------------
// Ethernet framing constants and the FCS
// word type for the GMII transmit path
// --------------------------------------

package gmii_tx_pkg;

	// --------------------------------------
	// Frame layout
	// --------------------------------------

	// Preamble byte, repeated before the start-of-frame delimiter
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;

	// Start-of-frame delimiter, the last byte before the payload
	localparam logic [7:0] SFD_BYTE = 8'hD5;

	// Seven preamble bytes precede the delimiter on the wire
	localparam int PREAMBLE_LEN = 7;

	// Short payloads are padded with zero bytes up to this length
	localparam int MIN_PAYLOAD_BYTES = 60;

	// The IPG is 96 bit times, so 12 byte clocks at gigabit rate
	localparam int IPG_CYCLES = 12;

	// The FCS is computed as a word and sent as bytes
	// Byte 0 holds the low bits and leaves first
	typedef union packed {
		logic [31:0]     word;
		logic [3:0][7:0] bytes;
	} fcs_word_t;

endpackage

/* src/axis_if.sv */
// --------------------------------------
// Stream interfaces: wide host words and
// single bytes, each with both modports
// --------------------------------------
`timescale 1ns/10ps

// Wide stream from the packet FIFO into the width converter
// Kept lanes are contiguous from lane 0
interface axis_wide_if #(
	parameter int AXIS_BYTES = 2
);
	logic [AXIS_BYTES*8-1:0] tdata;
	logic [AXIS_BYTES-1:0]   tkeep;
	logic                    tvalid;
	logic                    tready;
	logic                    tlast;

	modport source (output tdata, output tkeep, output tvalid, output tlast, input tready);
	modport sink (input tdata, input tkeep, input tvalid, input tlast, output tready);
endinterface

// Byte stream between the converter, the register slice and the MAC
// Every beat carries exactly one byte, so there is no tkeep
interface axis_byte_if;
	logic [7:0] tdata;
	logic       tvalid;
	logic       tready;
	logic       tlast;

	modport source (output tdata, output tvalid, output tlast, input tready);
	modport sink (input tdata, input tvalid, input tlast, output tready);
endinterface

/* src/gmii_tx_packet_fifo.sv */
// --------------------------------------
// Store-and-forward packet FIFO that only
// presents a frame once it is fully stored
// --------------------------------------
`timescale 1ns/10ps

module gmii_tx_packet_fifo #(
	parameter int AXIS_BYTES = 2,
	parameter int FIFO_WORDS = 128
) (
	input  logic                    clk,
	input  logic                    sresetn,

	// Host side
	input  logic [AXIS_BYTES*8-1:0] s_axis_tdata,
	input  logic [AXIS_BYTES-1:0]   s_axis_tkeep,
	input  logic                    s_axis_tvalid,
	input  logic                    s_axis_tlast,
	output logic                    s_axis_tready,

	// Toward the width converter
	axis_wide_if.source             out
);

	localparam int ADDR_W = $clog2(FIFO_WORDS);
	// One entry stores tlast, tkeep and tdata side by side
	localparam int ENTRY_W = AXIS_BYTES*8 + AXIS_BYTES + 1;

	logic [ENTRY_W-1:0] mem [FIFO_WORDS];
	logic [ENTRY_W-1:0] rd_entry;

	// Pointers carry one extra bit to tell full from empty
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;

	// Number of frames whose last word sits in the buffer
	logic [ADDR_W:0] frame_count;

	logic full;
	logic wr_fire;
	logic rd_fire;
	logic wr_last;
	logic rd_last;

	// --------------------------------------
	// Flags and handshakes
	// --------------------------------------

	// Full when the indexes match but the wrap bits differ
	assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
		(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
	assign s_axis_tready = !full;

	assign wr_fire = s_axis_tvalid && s_axis_tready;
	assign rd_fire = out.tvalid && out.tready;
	assign wr_last = wr_fire && s_axis_tlast;
	assign rd_last = rd_fire && out.tlast;

	// --------------------------------------
	// Storage
	// --------------------------------------

	always_ff @(posedge clk)
	begin
		if (wr_fire)
		begin
			mem[wr_ptr[ADDR_W-1:0]] <= {s_axis_tlast, s_axis_tkeep, s_axis_tdata};
		end
	end

	// Asynchronous read, so a word written on one edge shows up in the next cycle
	assign rd_entry = mem[rd_ptr[ADDR_W-1:0]];
	assign out.tdata = rd_entry[AXIS_BYTES*8-1:0];
	assign out.tkeep = rd_entry[AXIS_BYTES*8 +: AXIS_BYTES];
	assign out.tlast = rd_entry[ENTRY_W-1];

	// A frame that is partly read still has its last word stored, so it keeps
	// the count above zero and tvalid cannot drop in the middle of a frame
	assign out.tvalid = (frame_count != '0);

	// --------------------------------------
	// Pointer and frame count update
	// --------------------------------------

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			frame_count <= '0;
		end
		else
		begin
			if (wr_fire)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_fire)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// A frame may complete on the write side while another leaves
			case ({wr_last, rd_last})
				2'b10: frame_count <= frame_count + 1'b1;
				2'b01: frame_count <= frame_count - 1'b1;
				default: frame_count <= frame_count;
			endcase
		end
	end

endmodule

/* src/axis_width_converter.sv */
// --------------------------------------
// Wide-to-byte width converter that drops
// unkept lanes of the last word
// --------------------------------------
`timescale 1ns/10ps

module axis_width_converter #(
	parameter int AXIS_BYTES = 2
) (
	input  logic       clk,
	input  logic       sresetn,
	axis_wide_if.sink  in,
	axis_byte_if.source out
);

	// A single-lane stream still needs a one bit lane index
	localparam int LANE_W = (AXIS_BYTES > 1) ? $clog2(AXIS_BYTES) : 1;

	// Held word and its lane position
	logic [AXIS_BYTES*8-1:0] word_data;
	logic [AXIS_BYTES-1:0]   word_keep;
	logic                    word_last;
	logic                    word_valid;
	logic [LANE_W-1:0]       lane;

	// Bit n tells whether lane n+1 is kept, with zero above the top lane
	logic [AXIS_BYTES-1:0]   keep_above;
	logic                    last_lane;
	logic                    out_fire;

	assign keep_above = word_keep >> 1;

	// Lanes are contiguous, so the current lane is the last one to send
	// exactly when the lane above it is not kept
	assign last_lane = !keep_above[lane];

	assign out.tdata = word_data[lane*8 +: 8];
	assign out.tvalid = word_valid;
	assign out.tlast = word_last && last_lane;
	assign out_fire = word_valid && out.tready;

	// Take a new word while empty or in the cycle the final byte leaves
	assign in.tready = !word_valid || (out.tready && last_lane);

	// Word contents, loaded on every accepted wide beat
	always_ff @(posedge clk)
	begin
		if (in.tvalid && in.tready)
		begin
			word_data <= in.tdata;
			word_keep <= in.tkeep;
			word_last <= in.tlast;
		end
	end

	// Valid flag and lane index
	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			word_valid <= 1'b0;
			lane <= '0;
		end
		else if (in.tvalid && in.tready)
		begin
			word_valid <= 1'b1;
			lane <= '0;
		end
		else if (out_fire)
		begin
			// The last kept byte empties the holder, any other steps on
			word_valid <= !last_lane;
			lane <= lane + 1'b1;
		end
	end

endmodule

/* src/axis_byte_register.sv */
// --------------------------------------
// Byte stream skid register with
// registered valid and ready
// --------------------------------------
`timescale 1ns/10ps

module axis_byte_register (
	input  logic        clk,
	input  logic        sresetn,
	axis_byte_if.sink   in,
	axis_byte_if.source out
);

	// Main entry drives the output, the spare catches the beat that
	// was already in flight when ready dropped
	logic [7:0] main_data;
	logic       main_last;
	logic       main_valid;
	logic [7:0] spare_data;
	logic       spare_last;
	logic       spare_valid;
	logic       ready_r;

	logic       in_fire;
	logic       main_free;

	assign in.tready = ready_r;
	assign out.tdata = main_data;
	assign out.tlast = main_last;
	assign out.tvalid = main_valid;

	assign in_fire = in.tvalid && ready_r;
	// Main may load when it is empty or its beat leaves this cycle
	assign main_free = !main_valid || out.tready;

	always_ff @(posedge clk)
	begin
		if (main_free)
		begin
			// The spare is older than the input, so it goes first
			main_data <= spare_valid ? spare_data : in.tdata;
			main_last <= spare_valid ? spare_last : in.tlast;
		end
		if (in_fire && !main_free)
		begin
			spare_data <= in.tdata;
			spare_last <= in.tlast;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			main_valid <= 1'b0;
			spare_valid <= 1'b0;
			ready_r <= 1'b0;
		end
		else
		begin
			if (main_free)
			begin
				main_valid <= spare_valid || in_fire;
				spare_valid <= 1'b0;
			end
			else if (in_fire)
			begin
				spare_valid <= 1'b1;
			end
			// Ready next cycle only if the spare ends up empty
			ready_r <= main_free || !(spare_valid || in_fire);
		end
	end

endmodule

/* src/gmii_tx_mac.sv */
// --------------------------------------
// GMII transmit MAC: preamble, SFD, zero
// padding, FCS and inter-packet gap
// --------------------------------------
`timescale 1ns/10ps

module gmii_tx_mac (
	input  logic       clk,
	input  logic       sresetn,

	// Byte stream that never pauses inside a frame
	axis_byte_if.sink  in,

	output logic [7:0] eth_txd,
	output logic       eth_txen
);

	import gmii_tx_pkg::*;

	// Reflected form of the IEEE 802.3 CRC-32 polynomial
	localparam logic [31:0] CRC_POLY = 32'hEDB88320;

	// Terminal counts, all zero based on the shared counter
	localparam logic [5:0] PRE_LAST = 6'(PREAMBLE_LEN - 1);
	localparam logic [5:0] PAD_LAST = 6'(MIN_PAYLOAD_BYTES - 1);
	localparam logic [5:0] FCS_LAST = 6'd3;
	// The wait state supplies the last of the idle cycles
	localparam logic [5:0] GAP_LAST = 6'(IPG_CYCLES - 2);

	typedef enum logic [2:0] {
		ST_WAIT,
		ST_PREAMBLE,
		ST_SFD,
		ST_DATA,
		ST_FCS,
		ST_GAP
	} state_t;

	state_t     state;
	state_t     next_state;
	// Shared by every state and cleared on each state change
	logic [5:0] ctr;
	// Set once 60 bytes have gone out, since the counter wraps on long frames
	logic       length_ok;
	// Set after tlast, the rest of the data state is padding
	logic       last_seen;
	logic       byte_fire;
	logic [7:0] data_byte;
	logic [31:0] crc;
	logic [31:0] crc_upd;
	fcs_word_t  fcs;

	// Bitwise LSB-first CRC-32 step over one byte
	function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
		input logic [7:0] data);
		logic [31:0] c;
		c = crc_in ^ {24'd0, data};
		for (int i = 0; i < 8; i++)
		begin
			c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
		end
		return c;
	endfunction

	// Payload is pulled only in the data state and only up to tlast
	assign in.tready = (state == ST_DATA) && !last_seen;
	assign byte_fire = in.tvalid && in.tready;
	assign data_byte = last_seen ? 8'h00 : in.tdata;
	assign crc_upd = crc32_byte(crc, data_byte);

	// --------------------------------------
	// Next state
	// --------------------------------------

	always_comb
	begin
		next_state = state;
		case (state)
			ST_WAIT: if (in.tvalid) next_state = ST_PREAMBLE;
			ST_PREAMBLE: if (ctr == PRE_LAST) next_state = ST_SFD;
			ST_SFD: next_state = ST_DATA;
			// Leave once the minimum length is met and the payload has ended,
			// either earlier or with the byte going out now
			ST_DATA:
				if ((length_ok || ctr == PAD_LAST) &&
					(last_seen || (byte_fire && in.tlast)))
					next_state = ST_FCS;
			ST_FCS: if (ctr == FCS_LAST) next_state = ST_GAP;
			ST_GAP: if (ctr == GAP_LAST) next_state = ST_WAIT;
			default: next_state = ST_WAIT;
		endcase
	end

	// --------------------------------------
	// Control state
	// --------------------------------------

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			state <= ST_WAIT;
			ctr <= '0;
			length_ok <= 1'b0;
			last_seen <= 1'b0;
			eth_txen <= 1'b0;
		end
		else
		begin
			state <= next_state;
			ctr <= (next_state != state) ? 6'd0 : ctr + 6'd1;
			// The enable follows the state one cycle late, like the data
			eth_txen <= (state != ST_WAIT) && (state != ST_GAP);
			if (state == ST_WAIT)
			begin
				length_ok <= 1'b0;
				last_seen <= 1'b0;
			end
			else
			begin
				if (state == ST_DATA && ctr == PAD_LAST)
					length_ok <= 1'b1;
				if (byte_fire && in.tlast)
					last_seen <= 1'b1;
			end
		end
	end

	// --------------------------------------
	// Output byte and CRC
	// --------------------------------------

	always_ff @(posedge clk)
	begin
		eth_txd <= 8'h00;
		case (state)
			ST_WAIT: crc <= '1;
			ST_PREAMBLE: eth_txd <= PREAMBLE_BYTE;
			ST_SFD: eth_txd <= SFD_BYTE;
			ST_DATA:
			begin
				eth_txd <= data_byte;
				crc <= crc_upd;
				// Tracks the CRC so it is ready when the data state ends
				fcs.word <= ~crc_upd;
			end
			ST_FCS: eth_txd <= fcs.bytes[ctr[1:0]];
			default: eth_txd <= 8'h00;
		endcase
	end

endmodule

/* src/gmii_tx_top.sv */
// --------------------------------------
// GMII transmit subsystem: packet FIFO,
// width converter, byte register and MAC
// --------------------------------------
`timescale 1ns/10ps

module gmii_tx_top #(
	parameter int AXIS_BYTES = 2,
	parameter int FIFO_WORDS = 128
) (
	input  logic                    clk,
	input  logic                    sresetn,

	// Host stream, synchronous to the GMII transmit clock
	input  logic [AXIS_BYTES*8-1:0] s_axis_tdata,
	input  logic [AXIS_BYTES-1:0]   s_axis_tkeep,
	input  logic                    s_axis_tvalid,
	output logic                    s_axis_tready,
	input  logic                    s_axis_tlast,

	// GMII transmit port
	output logic [7:0]              eth_txd,
	output logic                    eth_txen
);

	axis_wide_if #(.AXIS_BYTES(AXIS_BYTES)) fifo_to_conv ();
	axis_byte_if conv_to_reg ();
	axis_byte_if reg_to_mac ();

	// Holds each frame until its last word has arrived
	gmii_tx_packet_fifo #(
		.AXIS_BYTES(AXIS_BYTES),
		.FIFO_WORDS(FIFO_WORDS)
	) packet_fifo (
		.clk(clk),
		.sresetn(sresetn),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tkeep(s_axis_tkeep),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tready(s_axis_tready),
		.out(fifo_to_conv.source)
	);

	axis_width_converter #(.AXIS_BYTES(AXIS_BYTES)) width_converter (
		.clk(clk),
		.sresetn(sresetn),
		.in(fifo_to_conv.sink),
		.out(conv_to_reg.source)
	);

	// Breaks the path from the converter lane mux into the MAC
	axis_byte_register byte_register (
		.clk(clk),
		.sresetn(sresetn),
		.in(conv_to_reg.sink),
		.out(reg_to_mac.source)
	);

	gmii_tx_mac mac (
		.clk(clk),
		.sresetn(sresetn),
		.in(reg_to_mac.sink),
		.eth_txd(eth_txd),
		.eth_txen(eth_txen)
	);

endmodule

/* dv/gmii_tx_tb.sv */
// --------------------------------------
// Testbench for the GMII transmit path
// Random frames, a byte and CRC model,
// wire capture and compare tasks
// --------------------------------------
`timescale 1ns/10ps

module gmii_tx_tb;

	import gmii_tx_pkg::*;

	// Matches the default width of the DUT
	localparam int AXIS_BYTES = 2;
	localparam int NUM_FRAMES = 40;

	logic                    clk;
	logic                    sresetn;
	logic [AXIS_BYTES*8-1:0] s_axis_tdata;
	logic [AXIS_BYTES-1:0]   s_axis_tkeep;
	logic                    s_axis_tvalid;
	logic                    s_axis_tready;
	logic                    s_axis_tlast;
	logic [7:0]              eth_txd;
	logic                    eth_txen;

	// Stimulus bytes, model bytes with padding, and per-frame expectations
	logic [7:0] tx_bytes [$];
	logic [7:0] exp_bytes [$];
	int         exp_len [$];
	fcs_word_t  exp_fcs [$];
	int         frame_len [NUM_FRAMES];
	logic [7:0] rx_frame [$];

	logic [31:0] rng;
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int frames_seen = 0;
	int low_cycles = 0;
	int txen_cycles = 0;
	int stall_cycles = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	// Error count when the current frame started on the wire
	int frame_errs_start = 0;
	logic txen_d = 1'b0;

	gmii_tx_top dut0 (
		.clk(clk),
		.sresetn(sresetn),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tkeep(s_axis_tkeep),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.s_axis_tlast(s_axis_tlast),
		.eth_txd(eth_txd),
		.eth_txen(eth_txen)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------
	// Random source, CRC model and compares
	// --------------------------------------

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// One bit at a time, LSB of the byte first, reflected polynomial
	function automatic logic [31:0] crc_add_byte(input logic [31:0] crc, input logic [7:0] b);
		logic [31:0] c;
		logic        fb;
		int          k;
		c = crc;
		for (k = 0; k < 8; k++)
		begin
			fb = c[0] ^ b[k];
			c = c >> 1;
			if (fb)
				c = c ^ 32'hEDB88320;
		end
		return c;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %02h, actual %02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_fcs(input string name, input fcs_word_t exp, input fcs_word_t act);
		if (act.word !== exp.word)
		begin
			$display("[FAIL] %s: expected %08h, actual %08h", name, exp.word, act.word);
			errors++;
		end
	endtask

	// With at_least set the actual value only has to reach the expected one
	task automatic check_count(input string name, input int exp, input int act,
		input bit at_least);
		if (at_least ? (act < exp) : (act != exp))
		begin
			$display("[FAIL] %s: expected %s%0d, actual %0d", name,
				at_least ? "at least " : "", exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors != errs_before)
			failed_tests++;
		$display("%s: %s", name, (errors == errs_before) ? "ok" : "errors");
	endtask

	// --------------------------------------
	// GMII monitor, sampled mid-cycle
	// --------------------------------------

	task automatic check_frame();
		string     name;
		int        len;
		int        errs_before;
		int        i;
		fcs_word_t got;
		fcs_word_t want;
		name = $sformatf("frame %0d", frames_seen);
		// The gap check at the start of the frame belongs to this test
		errs_before = frame_errs_start;
		if (exp_len.size() == 0)
		begin
			$display("A frame appeared on eth_txd that was never written");
			errors++;
		end
		else
		begin
			len = exp_len.pop_front();
			want = exp_fcs.pop_front();
			check_count({name, " length"}, 8 + len + 4, rx_frame.size(), 1'b0);
			if (rx_frame.size() == 8 + len + 4)
			begin
				for (i = 0; i < PREAMBLE_LEN; i++)
					check_byte($sformatf("%s preamble %0d", name, i), PREAMBLE_BYTE, rx_frame[i]);
				check_byte({name, " SFD"}, SFD_BYTE, rx_frame[7]);
				for (i = 0; i < len; i++)
					check_byte($sformatf("%s byte %0d", name, i), exp_bytes.pop_front(),
						rx_frame[8 + i]);
				// The first FCS byte on the wire is byte 0 of the word
				for (i = 0; i < 4; i++)
					got.bytes[i] = rx_frame[8 + len + i];
				check_fcs({name, " FCS"}, want, got);
			end
			else
			begin
				// Keep the model aligned with the next frame
				repeat (len) void'(exp_bytes.pop_front());
			end
		end
		report_test(name, errs_before);
		frames_seen++;
		rx_frame.delete();
	endtask

	always @(negedge clk)
	begin
		if (sresetn === 1'b1 && eth_txen === 1'b1)
		begin
			txen_cycles++;
			if (!txen_d)
			begin
				frame_errs_start = errors;
				if (frames_seen > 0)
					check_count($sformatf("gap before frame %0d", frames_seen), IPG_CYCLES,
						low_cycles, 1'b1);
			end
			rx_frame.push_back(eth_txd);
			low_cycles = 0;
		end
		else if (sresetn === 1'b1)
		begin
			if (txen_d)
				check_frame();
			low_cycles++;
		end
		txen_d = (eth_txen === 1'b1);
	end

	// Watchdog over the whole run
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d cycles with %0d of %0d frames received",
				cycle_count, frames_seen, NUM_FRAMES);
			$display("Testbench failed");
			$finish;
		end
	end

	// --------------------------------------
	// Host stream driver
	// --------------------------------------

	task automatic idle(input int n);
		s_axis_tvalid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	// Tready is read at the falling edge, where it is stable
	task automatic send_word(input logic [AXIS_BYTES*8-1:0] data,
		input logic [AXIS_BYTES-1:0] keep, input logic last);
		logic accepted;
		s_axis_tdata <= data;
		s_axis_tkeep <= keep;
		s_axis_tlast <= last;
		s_axis_tvalid <= 1'b1;
		do
		begin
			@(negedge clk);
			accepted = s_axis_tready;
			if (!accepted)
				stall_cycles++;
			@(posedge clk);
		end
		while (!accepted);
	endtask

	task automatic send_frame(input int len, input bit burst);
		logic [AXIS_BYTES*8-1:0] data;
		logic [AXIS_BYTES-1:0]   keep;
		int pos;
		int i;
		pos = 0;
		while (pos < len)
		begin
			data = '0;
			keep = '0;
			// Lanes fill from lane 0, so a short last word keeps its low lanes
			for (i = 0; i < AXIS_BYTES; i++)
			begin
				if (pos + i < len)
				begin
					data[i*8 +: 8] = tx_bytes.pop_front();
					keep[i] = 1'b1;
				end
			end
			pos += AXIS_BYTES;
			if (!burst)
			begin
				rng = xorshift(rng);
				idle(int'(rng % 4));
			end
			send_word(data, keep, pos >= len);
		end
	endtask

	// --------------------------------------
	// Main sequence
	// --------------------------------------

	initial
	begin
		int         f;
		int         i;
		int         padded;
		int         errs_before;
		logic [7:0] b;
		logic [31:0] crc;
		fcs_word_t  fcs;

		sresetn = 1'b0;
		s_axis_tdata = '0;
		s_axis_tkeep = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		rng = 32'h548ef6cc;

		// Build every frame and its expected wire image before the first edge
		for (f = 0; f < NUM_FRAMES; f++)
		begin
			rng = xorshift(rng);
			frame_len[f] = 1 + int'(rng % 200);
			padded = (frame_len[f] > MIN_PAYLOAD_BYTES) ? frame_len[f] : MIN_PAYLOAD_BYTES;
			crc = '1;
			for (i = 0; i < padded; i++)
			begin
				rng = xorshift(rng);
				b = (i < frame_len[f]) ? rng[7:0] : 8'h00;
				if (i < frame_len[f])
					tx_bytes.push_back(b);
				exp_bytes.push_back(b);
				crc = crc_add_byte(crc, b);
			end
			fcs.word = ~crc;
			exp_len.push_back(padded);
			exp_fcs.push_back(fcs);
			cycle_limit += (padded + 24) * 4;
		end
		cycle_limit += 1000;

		repeat (16) @(posedge clk);
		sresetn <= 1'b1;

		// Nothing may leave the MAC before a frame is written
		errs_before = errors;
		repeat (40) @(posedge clk);
		check_count("idle after reset", 0, txen_cycles, 1'b0);
		report_test("idle after reset", errs_before);

		// First half back to back to fill the FIFO, second half with gaps
		for (f = 0; f < NUM_FRAMES; f++)
			send_frame(frame_len[f], f < NUM_FRAMES / 2);
		idle(0);

		wait (frames_seen == NUM_FRAMES);
		repeat (200) @(posedge clk);

		errs_before = errors;
		check_count("host stalls on full FIFO", 1, stall_cycles, 1'b1);
		report_test("back-pressure", errs_before);

		errs_before = errors;
		check_count("frame count", NUM_FRAMES, frames_seen, 1'b0);
		report_test("frame count", errs_before);

		$display("Tests: %0d run, %0d failed, %0d check errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* src.f */
src/gmii_tx_pkg.sv
src/axis_if.sv
src/gmii_tx_packet_fifo.sv
src/axis_width_converter.sv
src/axis_byte_register.sv
src/gmii_tx_mac.sv
src/gmii_tx_top.sv
dv/gmii_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the GMII transmit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module gmii_tx_tb -o sim_gmii_tx

./obj_dir/sim_gmii_tx > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	exit 1
fi
exit 0
